//--- logic/cw_pkg.sv
package cw_pkg;

   localparam int num_tio        = 4;                 // target io lines
   localparam int io_route_bytes = 8;                 // routing register depth in bytes
   localparam int bus_bytecnt_w  = 7;                 // byte counter field on the bus
   localparam int pwroff_byte    = 5;                 // routing byte holding power control
   localparam int pwroff_bit     = 1;                 // power-off bit inside that byte
   localparam int oc_line        = 2;                 // line 3, zero based

   localparam logic [7:0] trigsrc_rst = 8'h20;        // OR mode, line 4 enabled
   localparam logic [io_route_bytes*8-1:0] iorouting_rst = 64'h0201; // line 1 tx, line 2 rx

   // register map, 38 (ext clock) is gone and falls to default
   typedef enum logic [5:0] {
      addr_trigsrc = 6'd39,
      addr_trigmod = 6'd40,
      addr_ioroute = 6'd55,
      addr_ioread  = 6'd59
   } cw_addr_e;

   typedef enum logic [1:0] {
      comb_or   = 2'b00,
      comb_and  = 2'b01,
      comb_nand = 2'b10,
      comb_off  = 2'b11
   } trig_combine_e;

   typedef enum logic [2:0] {
      mod_edge       = 3'd0,                          // combined external trigger
      mod_advio      = 3'd1,
      mod_anapattern = 3'd2,
      mod_decodedio  = 3'd3
   } trig_module_e;

   typedef struct packed {
      logic [5:0]               addr;
      logic [bus_bytecnt_w-1:0] bytecnt;              // byte index for multi-byte regs
      logic [7:0]               wdata;
      logic                     read;                 // read strobe
      logic                     write;                // write strobe
   } reg_bus_t;

   typedef struct packed {
      logic [7:0] trigsrc;                            // mode[7:6], enables[5:2]
      logic [7:0] trigmod;                            // module select in [2:0]
   } trig_cfg_t;

   // one routing byte per gpio line
   typedef struct packed {
      logic       gpio_en;                            // drive gpio_val
      logic       gpio_val;
      logic       tx_oc;                              // open-collector tx, line 3 only
      logic [2:0] usi;                                // old usi bits, stored only
      logic       rx;
      logic       tx;
   } gpio_route_t;

   typedef struct packed {
      gpio_route_t [num_tio-1:0] gpio;
      logic                      power_off;           // raw, not yet registered
   } io_cfg_t;

   typedef struct packed {
      logic [num_tio-1:0] oe;                         // per line output enable
      logic [num_tio-1:0] out;
   } tio_drive_t;

endpackage

//--- logic/cw_reg_bank.sv
`timescale 1ns/1ps

module cw_reg_bank #(
   parameter int bytecnt_w = 7
) (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  cw_pkg::reg_bus_t           bus_i,
   input  logic [cw_pkg::num_tio-1:0] tio_i,         // pad values
   output logic [7:0]                 rdata_o,
   output cw_pkg::trig_cfg_t          trig_cfg_o,
   output cw_pkg::io_cfg_t            io_cfg_o
);

   localparam int sel_w = $clog2(cw_pkg::io_route_bytes);

   logic [7:0]                                trigsrc_q;
   logic [7:0]                                trigmod_q;
   logic [cw_pkg::io_route_bytes-1:0][7:0]    iorouting_q;  // byte 0 = line 1
   logic [cw_pkg::num_tio-1:0]                ioread_q;     // sampled pads
   cw_pkg::cw_addr_e                          addr;
   logic [bytecnt_w-1:0]                      byte_idx;
   logic                                      byte_ok;
   logic [sel_w-1:0]                          byte_sel;

   assign addr     = cw_pkg::cw_addr_e'(bus_i.addr);
   assign byte_idx = bytecnt_w'(bus_i.bytecnt);
   assign byte_ok  = (byte_idx < bytecnt_w'(cw_pkg::io_route_bytes)); // 8+ ignored
   assign byte_sel = byte_idx[sel_w-1:0];

   // register writes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q   <= cw_pkg::trigsrc_rst;
         trigmod_q   <= '0;                           // edge trigger
         iorouting_q <= cw_pkg::iorouting_rst;
      end else if (bus_i.write) begin
         case (addr)
            cw_pkg::addr_trigsrc: trigsrc_q <= bus_i.wdata;
            cw_pkg::addr_trigmod: trigmod_q <= bus_i.wdata;
            cw_pkg::addr_ioroute: begin
               if (byte_ok) begin
                  iorouting_q[byte_sel] <= bus_i.wdata;
               end
            end
            default: ;                                // read-only or unmapped
         endcase
      end
   end

   // pads sampled every cycle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_q <= '0;
      end else begin
         ioread_q <= tio_i;
      end
   end

   // registered read mux, zero when idle
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         rdata_o <= '0;
      end else if (bus_i.read) begin
         case (addr)
            cw_pkg::addr_trigsrc: rdata_o <= trigsrc_q;
            cw_pkg::addr_trigmod: rdata_o <= trigmod_q;
            cw_pkg::addr_ioroute: rdata_o <= byte_ok ? iorouting_q[byte_sel] : 8'h00;
            cw_pkg::addr_ioread:  rdata_o <= {{(8-cw_pkg::num_tio){1'b0}}, ioread_q};
            default:              rdata_o <= '0;     // incl. old clock reg 38
         endcase
      end else begin
         rdata_o <= '0;
      end
   end

   assign trig_cfg_o.trigsrc = trigsrc_q;
   assign trig_cfg_o.trigmod = trigmod_q;

   assign io_cfg_o.gpio      = iorouting_q[cw_pkg::num_tio-1:0];  // bytes 0..3
   assign io_cfg_o.power_off = iorouting_q[cw_pkg::pwroff_byte][cw_pkg::pwroff_bit];

endmodule

//--- logic/trigger_route.sv
`timescale 1ns/1ps

module trigger_route (
   input  cw_pkg::trig_cfg_t          trig_cfg_i,
   input  logic [cw_pkg::num_tio-1:0] trig_io_i,     // rear target io triggers
   input  logic                       trig_advio_i,
   input  logic                       trig_anapattern_i,
   input  logic                       trig_decodedio_i,
   output logic                       trigger_ext_o,
   output logic                       trigger_o
);

   logic [cw_pkg::num_tio-1:0] trig_en;
   logic                       trig_or;
   logic                       trig_and;
   cw_pkg::trig_combine_e      comb_mode;
   cw_pkg::trig_module_e       mod_sel;

   assign trig_en   = trig_cfg_i.trigsrc[2 +: cw_pkg::num_tio];  // R1..R4 enables
   assign trig_or   = |(trig_io_i & trig_en);        // none enabled gives 0
   assign trig_and  = &(trig_io_i | ~trig_en);       // disabled input counts as 1
   assign comb_mode = cw_pkg::trig_combine_e'(trig_cfg_i.trigsrc[7:6]);
   assign mod_sel   = cw_pkg::trig_module_e'(trig_cfg_i.trigmod[2:0]);

   always_comb begin
      case (comb_mode)
         cw_pkg::comb_or:   trigger_ext_o = trig_or;
         cw_pkg::comb_and:  trigger_ext_o = trig_and;
         cw_pkg::comb_nand: trigger_ext_o = ~trig_and;
         default:           trigger_ext_o = 1'b0;     // off
      endcase
   end

   // trigger module select
   always_comb begin
      case (mod_sel)
         cw_pkg::mod_edge:       trigger_o = trigger_ext_o;
         cw_pkg::mod_advio:      trigger_o = trig_advio_i;
         cw_pkg::mod_anapattern: trigger_o = trig_anapattern_i;
         cw_pkg::mod_decodedio:  trigger_o = trig_decodedio_i;
         default:                trigger_o = 1'b0;    // codes 4..7 unused
      endcase
   end

endmodule

//--- logic/target_io_route.sv
`timescale 1ns/1ps

module target_io_route (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  cw_pkg::io_cfg_t            io_cfg_i,
   input  logic                       uart_tx_i,
   input  logic [cw_pkg::num_tio-1:0] tio_i,         // pad values
   output cw_pkg::tio_drive_t         tio_drive_o,
   output logic                       uart_rx_o,
   output logic                       targetpower_off_o
);

   logic power_off_q;                                // releases all lines

   // one extra stage on power-off
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         power_off_q <= 1'b0;                         // power on after reset
      end else begin
         power_off_q <= io_cfg_i.power_off;
      end
   end

   assign targetpower_off_o = power_off_q;

   // per line drive, first match wins
   always_comb begin
      tio_drive_o.oe  = '0;
      tio_drive_o.out = '0;
      for (int i = 0; i < cw_pkg::num_tio; i++) begin
         if (!power_off_q) begin
            if (io_cfg_i.gpio[i].tx) begin
               tio_drive_o.oe[i]  = 1'b1;
               tio_drive_o.out[i] = uart_tx_i;
            end else if (i == cw_pkg::oc_line && io_cfg_i.gpio[i].tx_oc) begin
               tio_drive_o.oe[i]  = ~uart_tx_i;       // pull low only, release on 1
               tio_drive_o.out[i] = 1'b0;
            end else if (io_cfg_i.gpio[i].gpio_en) begin
               tio_drive_o.oe[i]  = 1'b1;
               tio_drive_o.out[i] = io_cfg_i.gpio[i].gpio_val;
            end
         end
      end
   end

   // rx from lowest selected line, idle high otherwise
   always_comb begin
      uart_rx_o = 1'b1;
      for (int i = cw_pkg::num_tio - 1; i >= 0; i--) begin
         if (io_cfg_i.gpio[i].rx) begin
            uart_rx_o = tio_i[i];                     // lower index overrides
         end
      end
   end

endmodule

//--- logic/cw_reg_top.sv
`timescale 1ns/1ps

module cw_reg_top #(
   parameter int bytecnt_w = 7
) (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  cw_pkg::reg_bus_t           bus_i,
   output logic [7:0]                 rdata_o,
   input  logic [cw_pkg::num_tio-1:0] trig_io_i,
   input  logic                       trig_advio_i,
   input  logic                       trig_anapattern_i,
   input  logic                       trig_decodedio_i,
   output logic                       trigger_ext_o,
   output logic                       trigger_o,
   input  logic                       uart_tx_i,
   output logic                       uart_rx_o,
   input  logic [cw_pkg::num_tio-1:0] tio_i,         // pad values from outside
   output cw_pkg::tio_drive_t         tio_drive_o,
   output logic                       targetpower_off_o
);

   cw_pkg::trig_cfg_t trig_cfg;                      // bank to trigger router
   cw_pkg::io_cfg_t   io_cfg;                        // bank to io router

   cw_reg_bank #(
      .bytecnt_w (bytecnt_w)
   ) i_cw_reg_bank (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .bus_i      (bus_i),
      .tio_i      (tio_i),
      .rdata_o    (rdata_o),
      .trig_cfg_o (trig_cfg),
      .io_cfg_o   (io_cfg)
   );

   trigger_route i_trigger_route (
      .trig_cfg_i        (trig_cfg),
      .trig_io_i         (trig_io_i),
      .trig_advio_i      (trig_advio_i),
      .trig_anapattern_i (trig_anapattern_i),
      .trig_decodedio_i  (trig_decodedio_i),
      .trigger_ext_o     (trigger_ext_o),
      .trigger_o         (trigger_o)
   );

   target_io_route i_target_io_route (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .io_cfg_i          (io_cfg),
      .uart_tx_i         (uart_tx_i),
      .tio_i             (tio_i),
      .tio_drive_o       (tio_drive_o),
      .uart_rx_o         (uart_rx_o),
      .targetpower_off_o (targetpower_off_o)
   );

endmodule

//--- sim/cw_reg_checker.sv
`timescale 1ns/1ps

module cw_reg_checker (
   input  logic               clk_usb,
   input  logic               reset,
   input  logic               chk_valid_i,     // expectation posted this cycle
   input  logic [1:0]         chk_kind_i,      // 0 read, 1 trigger, 2 pads
   input  logic [127:0]       chk_name_i,
   input  logic [15:0]        chk_exp_i,
   input  logic [7:0]         rdata_i,
   input  logic               trigger_ext_i,
   input  logic               trigger_i,
   input  cw_pkg::tio_drive_t tio_drive_i,
   input  logic               uart_rx_i,
   input  logic               targetpower_off_i,
   output int                 err_cnt_o,
   output int                 test_cnt_o
);

   int           err_cnt  = 0;
   int           test_cnt = 0;
   logic         rd_pend;                          // read data due next edge
   logic [127:0] rd_name;
   logic [7:0]   rd_exp;

   assign err_cnt_o  = err_cnt;
   assign test_cnt_o = test_cnt;

   task automatic score(input logic [127:0] name, input logic [15:0] exp_v,
                        input logic [15:0] act_v);
      test_cnt++;
      if (act_v !== exp_v) begin
         err_cnt++;
         $display("** Error %0s: expected %0h, actual %0h", name, exp_v, act_v);
      end else begin
         $display("   ok    %0s: %0h", name, act_v);
      end
   endtask

   task automatic print_counts(input int sva_fails);
      $display("checks run %0d, errors %0d, assertion failures %0d",
               test_cnt, err_cnt, sva_fails);
   endtask

   // sampled on the rising edge before flops update
   always @(posedge clk_usb) begin
      if (reset) begin
         rd_pend <= 1'b0;
      end else begin
         if (rd_pend) begin
            score(rd_name, {8'h00, rd_exp}, {8'h00, rdata_i});   // one cycle read latency
         end
         rd_pend <= chk_valid_i && (chk_kind_i == 2'd0);
         rd_name <= chk_name_i;
         rd_exp  <= chk_exp_i[7:0];
         if (chk_valid_i && chk_kind_i == 2'd1) begin
            score(chk_name_i, {14'h0, chk_exp_i[1:0]}, {14'h0, trigger_ext_i, trigger_i});
         end
         if (chk_valid_i && chk_kind_i == 2'd2) begin
            score(chk_name_i, chk_exp_i,
                  {6'h0, targetpower_off_i, uart_rx_i, tio_drive_i});
         end
      end
   end

endmodule

//--- sim/cw_reg_props.sv
`timescale 1ns/1ps

module cw_reg_props (
   input logic               clk_usb,
   input logic               reset,
   input cw_pkg::reg_bus_t   bus_i,
   input logic [7:0]         rdata_i,
   input cw_pkg::io_cfg_t    io_cfg_i,
   input cw_pkg::tio_drive_t drive_i,
   input logic               uart_rx_i,
   input logic               pwroff_i
);

   logic any_rx;                                   // some line sources uart rx
   int   fail_cnt = 0;                             // assertion failures so far

   assign any_rx = io_cfg_i.gpio[0].rx | io_cfg_i.gpio[1].rx |
                   io_cfg_i.gpio[2].rx | io_cfg_i.gpio[3].rx;

   a_pwroff_release: assert property (@(posedge clk_usb) disable iff (reset)
      pwroff_i |-> (drive_i.oe == '0))
      else begin
         fail_cnt++;
         $error("output enable set while target power is off");
      end

   a_idle_rdata: assert property (@(posedge clk_usb) disable iff (reset)
      !bus_i.read |=> (rdata_i == 8'h00))
      else begin
         fail_cnt++;
         $error("read data not zero after an idle cycle");
      end

   a_rx_idle: assert property (@(posedge clk_usb) disable iff (reset)
      !any_rx |-> uart_rx_i)
      else begin
         fail_cnt++;
         $error("uart rx low with no rx line selected");
      end

endmodule

bind cw_reg_top cw_reg_props i_cw_reg_props (
   .clk_usb  (clk_usb),
   .reset    (reset),
   .bus_i    (bus_i),
   .rdata_i  (rdata_o),
   .io_cfg_i (io_cfg),
   .drive_i  (tio_drive_o),
   .uart_rx_i(uart_rx_o),
   .pwroff_i (targetpower_off_o)
);

//--- sim/tb_cw_reg.sv
`timescale 1ns/1ps

module tb_cw_reg;

   localparam int max_ops    = 64;                  // trace capacity
   localparam int cyc_per_op = 20;                  // watchdog budget per op

   logic               clk_usb;
   logic               reset;
   cw_pkg::reg_bus_t   bus;
   logic [3:0]         trig_io;
   logic               trig_advio;
   logic               trig_anapattern;
   logic               trig_decodedio;
   logic               uart_tx;
   logic [3:0]         ext_pads;                    // value seen on released pads
   logic [3:0]         tio_pads;
   logic [7:0]         rdata;
   logic               trigger_ext;
   logic               trigger;
   logic               uart_rx;
   logic               power_off;
   cw_pkg::tio_drive_t tio_drive;
   logic               chk_valid;
   logic [1:0]         chk_kind;                    // 0 read, 1 trigger, 2 pads
   logic [127:0]       chk_name;
   logic [15:0]        chk_exp;
   int                 err_cnt;
   int                 test_cnt;
   int                 sva_fails;                   // from the bound assertions
   logic [7:0]         op_code [max_ops];
   logic [127:0]       op_name [max_ops];
   logic [15:0]        op_f    [max_ops][4];
   int                 n_ops;
   int                 n_checks;
   logic               loaded;
   logic               trace_bad;

   always #5 clk_usb = ~clk_usb;                    // 10 ns period

   // pad model, driven value wins over the external one
   assign tio_pads = (tio_drive.oe & tio_drive.out) | (~tio_drive.oe & ext_pads);

   cw_reg_top #(
      .bytecnt_w (7)
   ) i_cw_reg_top (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .bus_i             (bus),
      .rdata_o           (rdata),
      .trig_io_i         (trig_io),
      .trig_advio_i      (trig_advio),
      .trig_anapattern_i (trig_anapattern),
      .trig_decodedio_i  (trig_decodedio),
      .trigger_ext_o     (trigger_ext),
      .trigger_o         (trigger),
      .uart_tx_i         (uart_tx),
      .uart_rx_o         (uart_rx),
      .tio_i             (tio_pads),
      .tio_drive_o       (tio_drive),
      .targetpower_off_o (power_off)
   );

   cw_reg_checker i_cw_reg_checker (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .chk_valid_i       (chk_valid),
      .chk_kind_i        (chk_kind),
      .chk_name_i        (chk_name),
      .chk_exp_i         (chk_exp),
      .rdata_i           (rdata),
      .trigger_ext_i     (trigger_ext),
      .trigger_i         (trigger),
      .tio_drive_i       (tio_drive),
      .uart_rx_i         (uart_rx),
      .targetpower_off_i (power_off),
      .err_cnt_o         (err_cnt),
      .test_cnt_o        (test_cnt)
   );

   task automatic load_trace();
      int           fd;
      int           cnt;
      string        line;
      logic [7:0]   op;
      logic [127:0] name;
      logic [15:0]  f0, f1, f2, f3;
      n_ops    = 0;
      n_checks = 0;
      fd = $fopen("sim/cw_reg_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file sim/cw_reg_trace.txt");
         trace_bad = 1'b1;
         return;
      end
      while (!$feof(fd) && n_ops < max_ops) begin
         cnt = $fgets(line, fd);
         if (cnt > 0 && line[0] != "#") begin   // skip column notes
            cnt = $sscanf(line, "%s %s %h %h %h %h", op, name, f0, f1, f2, f3);
            if (cnt == 6) begin
               op_code[n_ops] = op;
               op_name[n_ops] = name;
               op_f[n_ops][0] = f0;
               op_f[n_ops][1] = f1;
               op_f[n_ops][2] = f2;
               op_f[n_ops][3] = f3;
               if (op != "W") n_checks++;
               n_ops++;
            end
         end
      end
      $fclose(fd);
   endtask

   // one trace line per falling edge
   task automatic apply_op(input int k);
      bus       = '0;                               // strobes last one cycle
      chk_valid = 1'b0;
      chk_name  = op_name[k];
      case (op_code[k])
         "W": begin
            bus.addr    = op_f[k][0][5:0];
            bus.bytecnt = op_f[k][1][6:0];
            bus.wdata   = op_f[k][2][7:0];
            bus.write   = 1'b1;
         end
         "R": begin
            bus.addr    = op_f[k][0][5:0];
            bus.bytecnt = op_f[k][1][6:0];
            bus.read    = 1'b1;
            chk_kind    = 2'd0;
            chk_exp     = {8'h00, op_f[k][2][7:0]};
            chk_valid   = 1'b1;
         end
         "T": begin
            trig_io = op_f[k][0][3:0];
            {trig_advio, trig_anapattern, trig_decodedio} = op_f[k][1][2:0];
            chk_kind  = 2'd1;
            chk_exp   = {14'h0, op_f[k][2][0], op_f[k][3][0]};
            chk_valid = 1'b1;
         end
         "P": begin
            ext_pads  = op_f[k][0][3:0];
            uart_tx   = op_f[k][1][0];
            chk_kind  = 2'd2;
            chk_exp   = {6'h0, op_f[k][3][1:0], op_f[k][2][7:0]};  // pwroff, rx, drive
            chk_valid = 1'b1;
         end
         default: begin
            $display("unknown operation in trace line %0d", k);
            trace_bad = 1'b1;
         end
      endcase
   endtask

   initial begin
      clk_usb         = 1'b0;
      reset           = 1'b1;
      bus             = '0;
      trig_io         = '0;
      trig_advio      = 1'b0;
      trig_anapattern = 1'b0;
      trig_decodedio  = 1'b0;
      uart_tx         = 1'b1;                       // uart idle
      ext_pads        = 4'hf;                       // pull-ups on released pads
      chk_valid       = 1'b0;
      chk_kind        = 2'd0;
      chk_name        = '0;
      chk_exp         = '0;
      trace_bad       = 1'b0;
      loaded          = 1'b0;
      load_trace();
      loaded = 1'b1;
      repeat (4) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;
      for (int k = 0; k < n_ops; k++) begin
         @(negedge clk_usb);
         apply_op(k);
      end
      @(negedge clk_usb);
      bus       = '0;
      chk_valid = 1'b0;
      repeat (2) @(negedge clk_usb);                // let the last read land
      sva_fails = i_cw_reg_top.i_cw_reg_props.fail_cnt;
      i_cw_reg_checker.print_counts(sva_fails);
      if (test_cnt != n_checks) begin
         $display("only %0d of %0d checks were run", test_cnt, n_checks);
      end
      if (!trace_bad && err_cnt == 0 && sva_fails == 0 &&
          n_checks > 0 && test_cnt == n_checks) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // watchdog sized from the trace length
   initial begin
      wait (loaded);
      repeat (n_ops * cyc_per_op + 50) @(posedge clk_usb);
      $display("timeout, the trace did not finish within %0d cycles", n_ops * cyc_per_op + 50);
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- sim/cw_reg_trace.txt
# op name f0 f1 f2 f3, hex. W addr bytecnt wdata 0. R addr bytecnt expected 0
# T trig_io {advio,anapattern,decodedio} exp_ext exp_trig. P pads uart_tx exp_{oe,out} {pwroff,rx}
R rst_trigsrc 27 0 20 0
R rst_trigmod 28 0 00 0
R rst_route0 37 0 01 0
R rst_route1 37 1 02 0
R clk_reg_38 26 0 00 0
R unmapped 3f 0 00 0
P rst_tx_line1 f 1 11 1
T or_l4_hi 8 0 1 1
W src_or_all 27 0 3c 0
T or_all_hi 2 0 1 1
W src_and_13 27 0 54 0
T and_13_hi 5 0 1 1
T and_13_lo 4 0 0 0
W src_nand_13 27 0 94 0
T nand_13_hi 1 0 1 1
T nand_13_lo f 0 0 0
W src_off 27 0 fc 0
T off_all f 0 0 0
R src_rb 27 0 fc 0
W mod_advio 28 0 01 0
T sel_advio 0 4 0 1
W mod_anapat 28 0 02 0
T sel_anapat 0 2 0 1
W mod_decoded 28 0 03 0
T sel_decoded 0 6 0 0
W mod_unused 28 0 05 0
T sel_unused f 7 0 0
R mod_rb 28 0 05 0
W oc_l3 37 2 20 0
W gpio_l4 37 3 c0 0
P oc_tx_hi f 1 99 1
P oc_tx_lo d 0 d8 0
W route_oob 37 8 ff 0
R route_oob_rd 37 8 00 0
R route0_keep 37 0 01 0
W rx_l1 37 0 02 0
P rx_lowest e 1 88 0
R ioread 3b 0 0e 0
W no_rx_l1 37 0 00 0
W no_rx_l2 37 1 00 0
P rx_default 0 1 88 1
W pwr_off 37 5 02 0
P pwr_delay 0 1 88 1
P pwr_released 0 1 00 3
W pwr_on 37 5 00 0
P pwr_hold 0 1 00 3
P pwr_restored 0 1 88 1

//--- tb.f
logic/cw_pkg.sv
logic/cw_reg_bank.sv
logic/trigger_route.sv
logic/target_io_route.sv
logic/cw_reg_top.sv
sim/cw_reg_checker.sv
sim/cw_reg_props.sv
sim/tb_cw_reg.sv

//--- Bender.yml
package:
  name: cw_reg

sources:
  - logic/cw_pkg.sv
  - logic/cw_reg_bank.sv
  - logic/trigger_route.sv
  - logic/target_io_route.sv
  - logic/cw_reg_top.sv
  - target: simulation
    files:
      - sim/cw_reg_checker.sv
      - sim/cw_reg_props.sv
      - sim/tb_cw_reg.sv
